// File: list.f
+incdir+rtl
rtl/conv_data_pkg.sv
rtl/conv_ctrl_pkg.sv
rtl/tap_shift.sv
rtl/pe_array.sv
rtl/psum_buf.sv
rtl/ofm_writeback.sv
rtl/conv_seq.sv
rtl/conv_acc.sv
tb/conv_acc_assertions.sv
tb/tb_conv_acc.sv

// File: Makefile
SIM = obj_dir/Vtb_conv_acc

all: run

$(SIM): list.f $(wildcard rtl/*.sv rtl/*.svh tb/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_conv_acc \
		-f list.f -Mdir obj_dir

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: tb/tb_conv_acc.sv
////////////////////////////////////////////////////////////
// Testbench for the convolution engine
// Random runs, reference sums, read counts and summary
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "conv_settings.svh"

module tb_conv_acc;
    import conv_data_pkg::*;
    import conv_ctrl_pkg::*;

    localparam int RUNS    = 6;
    localparam int MAX_CH  = 4;
    localparam int IFM_LEN = RUNS * MAX_CH * `IFM_COLS + 1;
    localparam int WGT_LEN = RUNS * MAX_CH * `KSIZE + 1;
    localparam int TIMEOUT = RUNS * (4 * `IFM_COLS + `OUT_COLS + 16);

    logic       clk = 1'b0;
    logic       rst_n;
    logic       start;
    cfg_ci_t    cfg_ci;
    ifm_col_t   ifm = '0;
    wgt_col_t   weight = '0;
    logic       ifm_read;
    logic       wgt_read;
    ofm_col_t   ofm;
    logic       ofm_valid;
    logic       done;

    // Column streams of all runs back to back
    ifm_col_t   ifm_stream [IFM_LEN];
    wgt_col_t   wgt_stream [WGT_LEN];
    int         ifm_pos = 0;
    int         wgt_pos = 0;
    cfg_ci_t    run_ci [RUNS];
    string      run_name [RUNS];
    psum_t      exp_ofm [RUNS][`OUT_COLS][`OUT_ROWS];
    int         run_idx = 0;
    int         out_col = 0;
    int         ifm_cnt = 0;
    int         wgt_cnt = 0;
    int         error_count = 0;
    int         cycle_count = 0;

    conv_acc u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .cfg_ci    (cfg_ci),
        .ifm       (ifm),
        .weight    (weight),
        .ifm_read  (ifm_read),
        .wgt_read  (wgt_read),
        .ofm       (ofm),
        .ofm_valid (ofm_valid),
        .done      (done)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic bit has_restart(input int r);
        return (r == 2) || (r == 4);
    endfunction

    // Random data per run and the expected output columns
    task automatic build_runs();
        logic [31:0] rng;
        int          ib;
        int          wb;
        int          nch;
        rng = 32'd58;
        ib  = 0;
        wb  = 0;
        for (int r = 0; r < RUNS; r++) begin
            rng = xorshift(rng);
            if (r == 0) begin
                run_ci[r] = '0;
            end else if (r == 1) begin
                run_ci[r] = cfg_ci_t'(MAX_CH - 1);
            end else begin
                run_ci[r] = rng[1:0];
            end
            run_name[r] = $sformatf("run%0d_ci%0d%s", r, run_ci[r],
                                    has_restart(r) ? "_restart" : "");
            nch = int'(run_ci[r]) + 1;
            for (int i = 0; i < nch * `IFM_COLS; i++) begin
                for (int l = 0; l < `IFM_ROWS; l++) begin
                    rng = xorshift(rng);
                    ifm_stream[ib + i].px[l] = rng[7:0];
                end
            end
            for (int i = 0; i < nch * `KSIZE; i++) begin
                for (int k = 0; k < `KSIZE; k++) begin
                    rng = xorshift(rng);
                    wgt_stream[wb + i].w[k] = rng[7:0];
                end
            end
            // Weight column j of a channel meets IFM column c+j
            for (int c = 0; c < `OUT_COLS; c++) begin
                for (int o = 0; o < `OUT_ROWS; o++) begin
                    exp_ofm[r][c][o] = '0;
                    for (int ch = 0; ch < nch; ch++) begin
                        for (int k = 0; k < `KSIZE; k++) begin
                            for (int j = 0; j < `KSIZE; j++) begin
                                exp_ofm[r][c][o] += psum_t'(wgt_stream[wb + ch * `KSIZE + j].w[k])
                                    * psum_t'(ifm_stream[ib + ch * `IFM_COLS + c + j].px[o + k]);
                            end
                        end
                    end
                end
            end
            ib += nch * `IFM_COLS;
            wb += nch * `KSIZE;
        end
    endtask

    task automatic check_count(input string what, input int expected, input int actual);
        if (expected != actual) begin
            $display("Mismatch %s %s: expected %0d, actual %0d",
                     run_name[run_idx], what, expected, actual);
            error_count++;
        end
    endtask

    task automatic finish_run(input bit timed_out);
        int assert_errors;
        int total;
        assert_errors = int'(u_dut.u_assert.fail_count);
        total = error_count + assert_errors + (timed_out ? 1 : 0);
        $display("Errors: %0d total, %0d check, %0d assertion, %0d timeout",
                 total, error_count, assert_errors, timed_out ? 1 : 0);
        if (total == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    ////////////////////////////////////////////////////////////
    // Column source, next column after each read strobe
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (ifm_read) begin
            ifm     <= ifm_stream[ifm_pos + 1];
            ifm_pos <= ifm_pos + 1;
        end else begin
            ifm <= ifm_stream[ifm_pos];
        end
        if (wgt_read) begin
            weight  <= wgt_stream[wgt_pos + 1];
            wgt_pos <= wgt_pos + 1;
        end else begin
            weight <= wgt_stream[wgt_pos];
        end
    end

    // Output compare and per-run counts
    always @(posedge clk) begin
        if (rst_n) begin
            if (ifm_read) begin
                ifm_cnt++;
            end
            if (wgt_read) begin
                wgt_cnt++;
            end
            if (ofm_valid) begin
                if (out_col < `OUT_COLS) begin
                    for (int o = 0; o < `OUT_ROWS; o++) begin
                        if (ofm.row[o] !== exp_ofm[run_idx][out_col][o]) begin
                            $display("Mismatch %s col %0d row %0d: expected %0d, actual %0d",
                                     run_name[run_idx], out_col, o,
                                     exp_ofm[run_idx][out_col][o], ofm.row[o]);
                            error_count++;
                        end
                    end
                end
                out_col++;
            end
            if (done) begin
                check_count("ofm words", `OUT_COLS, out_col);
                check_count("ifm_read cycles", `IFM_COLS * (int'(run_ci[run_idx]) + 1), ifm_cnt);
                check_count("wgt_read cycles", `KSIZE * (int'(run_ci[run_idx]) + 1), wgt_cnt);
                out_col = 0;
                ifm_cnt = 0;
                wgt_cnt = 0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT) begin
            $display("Timeout: the runs did not finish within %0d cycles", TIMEOUT);
            finish_run(1'b1);
        end
    end

    initial begin
        build_runs();
        rst_n  <= 1'b0;
        start  <= 1'b0;
        cfg_ci <= '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        for (int r = 0; r < RUNS; r++) begin
            @(posedge clk);
            run_idx = r;
            start  <= 1'b1;
            cfg_ci <= run_ci[r];
            @(posedge clk);
            start <= 1'b0;
            // Second start while reading, with another channel count
            if (has_restart(r)) begin
                repeat (2) @(posedge clk);
                start  <= 1'b1;
                cfg_ci <= ~run_ci[r];
                @(posedge clk);
                start <= 1'b0;
            end
            while (!done) @(posedge clk);
        end
        repeat (2) @(posedge clk);
        finish_run(1'b0);
    end

endmodule

// File: tb/conv_acc_assertions.sv
////////////////////////////////////////////////////////////
// Port protocol assertions for the convolution engine
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "conv_settings.svh"

module conv_acc_assertions (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  conv_ctrl_pkg::cfg_ci_t      cfg_ci,
    input  logic                        ifm_read,
    input  logic                        wgt_read,
    input  logic                        ofm_valid,
    input  logic                        done
);
    import conv_ctrl_pkg::*;

    logic           started;
    logic           in_run;
    cfg_ci_t        ci_q;
    logic [7:0]     ifm_cnt;
    logic [7:0]     wgt_cnt;
    logic [3:0]     valid_run;
    int unsigned    fail_count = 0;

    // Run tracking, a start inside a run is ignored like in the sequencer
    always @(posedge clk) begin
        if (!rst_n) begin
            started   <= 1'b0;
            in_run    <= 1'b0;
            ci_q      <= '0;
            ifm_cnt   <= '0;
            wgt_cnt   <= '0;
            valid_run <= '0;
        end else begin
            if (start) begin
                started <= 1'b1;
            end
            if (start && !in_run) begin
                in_run  <= 1'b1;
                ci_q    <= cfg_ci;
                ifm_cnt <= '0;
                wgt_cnt <= '0;
            end else begin
                if (done) begin
                    in_run <= 1'b0;
                end
                if (ifm_read) begin
                    ifm_cnt <= ifm_cnt + 8'd1;
                end
                if (wgt_read) begin
                    wgt_cnt <= wgt_cnt + 8'd1;
                end
            end
            valid_run <= ofm_valid ? valid_run + 4'd1 : 4'd0;
        end
    end

    a_quiet_before_start: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> !ifm_read && !wgt_read && !ofm_valid && !done)
        else begin
            $error("Outputs active before the first start");
            fail_count = fail_count + 1;
        end

    a_reads_in_run: assert property (@(posedge clk) disable iff (!rst_n)
        (ifm_read || wgt_read) |-> in_run && ifm_read)
        else begin
            $error("Read strobe outside a run or weight read without IFM read");
            fail_count = fail_count + 1;
        end

    a_read_counts: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> ifm_cnt == 8'(`IFM_COLS * (int'(ci_q) + 1))
              && wgt_cnt == 8'(`KSIZE * (int'(ci_q) + 1)))
        else begin
            $error("Wrong number of read strobes in a run");
            fail_count = fail_count + 1;
        end

    // Exactly OUT_COLS valid words, then done
    a_valid_burst: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(ofm_valid) |-> done && valid_run == 4'(`OUT_COLS))
        else begin
            $error("Valid burst of wrong length or not followed by done");
            fail_count = fail_count + 1;
        end

    a_valid_max: assert property (@(posedge clk) disable iff (!rst_n)
        ofm_valid |-> valid_run < 4'(`OUT_COLS))
        else begin
            $error("Valid burst longer than the output columns");
            fail_count = fail_count + 1;
        end

    a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> $fell(ofm_valid) ##1 !done)
        else begin
            $error("Done not a single pulse right after the last valid");
            fail_count = fail_count + 1;
        end

endmodule

bind conv_acc conv_acc_assertions u_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .cfg_ci    (cfg_ci),
    .ifm_read  (ifm_read),
    .wgt_read  (wgt_read),
    .ofm_valid (ofm_valid),
    .done      (done)
);

// File: rtl/conv_acc.sv
////////////////////////////////////////////////////////////
// Convolution engine top level
// Sequencer, line buffers, PE array, psum buffer, write-back
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "conv_settings.svh"

module conv_acc (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  conv_ctrl_pkg::cfg_ci_t      cfg_ci,
    input  conv_data_pkg::ifm_col_t     ifm,
    input  conv_data_pkg::wgt_col_t     weight,
    output logic                        ifm_read,
    output logic                        wgt_read,
    output conv_data_pkg::ofm_col_t     ofm,
    output logic                        ofm_valid,
    output logic                        done
);
    import conv_data_pkg::*;
    import conv_ctrl_pkg::*;

    psum_ctrl_t                              psum_ctrl;
    pixel_t [`IFM_ROWS-1:0][`KSIZE-1:0]      ifm_taps;
    pixel_t [`KSIZE-1:0][`KSIZE-1:0]         wgt_taps;
    psum_t [`OUT_ROWS-1:0]                   sums;
    logic [$clog2(`OUT_COLS)-1:0]            rd_col;
    ofm_col_t                                done_col;
    logic                                    ready;

    conv_seq u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .cfg_ci    (cfg_ci),
        .done      (done),
        .ifm_read  (ifm_read),
        .wgt_read  (wgt_read),
        .psum_ctrl (psum_ctrl)
    );

    ////////////////////////////////////////////////////////////
    // Line buffers
    ////////////////////////////////////////////////////////////

    tap_shift #(.LANES(`IFM_ROWS)) u_ifm_taps (
        .clk      (clk),
        .rst_n    (rst_n),
        .shift    (ifm_read),
        .lanes_in (ifm.px),
        .taps     (ifm_taps)
    );

    tap_shift #(.LANES(`KSIZE)) u_wgt_taps (
        .clk      (clk),
        .rst_n    (rst_n),
        .shift    (wgt_read),
        .lanes_in (weight.w),
        .taps     (wgt_taps)
    );

    ////////////////////////////////////////////////////////////
    // Compute and accumulate
    ////////////////////////////////////////////////////////////

    pe_array u_pe (
        .clk      (clk),
        .rst_n    (rst_n),
        .ifm_taps (ifm_taps),
        .wgt_taps (wgt_taps),
        .sums     (sums)
    );

    psum_buf u_psum (
        .clk       (clk),
        .rst_n     (rst_n),
        .psum_ctrl (psum_ctrl),
        .sums      (sums),
        .rd_col    (rd_col),
        .ofm       (done_col),
        .ready     (ready)
    );

    ofm_writeback u_wb (
        .clk       (clk),
        .rst_n     (rst_n),
        .ready     (ready),
        .ofm_in    (done_col),
        .rd_col    (rd_col),
        .ofm       (ofm),
        .ofm_valid (ofm_valid),
        .done      (done)
    );

endmodule

// File: rtl/conv_seq.sv
////////////////////////////////////////////////////////////
// Run and channel sequencer
// Read strobes and partial-sum commands
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "conv_settings.svh"

module conv_seq (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  conv_ctrl_pkg::cfg_ci_t      cfg_ci,
    input  logic                        done,
    output logic                        ifm_read,
    output logic                        wgt_read,
    output conv_ctrl_pkg::psum_ctrl_t   psum_ctrl
);
    import conv_ctrl_pkg::*;

    localparam int COL_W = $clog2(`IFM_COLS);
    localparam int IDX_W = $clog2(`OUT_COLS);

    typedef enum logic [1:0] {
        s_idle,
        s_read,
        s_drain
    } state_t;

    state_t             state;
    logic [COL_W-1:0]   col;
    cfg_ci_t            ch;
    cfg_ci_t            ci_q;
    logic               last_col;
    logic [COL_W-1:0]   win_col;
    psum_ctrl_t         ctrl_tap;

    assign last_col = (col == COL_W'(`IFM_COLS - 1));
    assign ifm_read = (state == s_read);
    assign wgt_read = ifm_read && (col < COL_W'(`KSIZE));
    // Window column of the read that completes it
    assign win_col  = col - COL_W'(`KSIZE - 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= s_idle;
            col   <= '0;
            ch    <= '0;
            ci_q  <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (start) begin
                        state <= s_read;
                        ci_q  <= cfg_ci;
                        col   <= '0;
                        ch    <= '0;
                    end
                end
                s_read: begin
                    if (last_col) begin
                        col <= '0;
                        if (ch == ci_q) begin
                            state <= s_drain;
                        end else begin
                            ch <= ch + 1'b1;
                        end
                    end else begin
                        col <= col + 1'b1;
                    end
                end
                // Wait for the write-back to finish
                s_drain: begin
                    if (done) begin
                        state <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Command pipe
    ////////////////////////////////////////////////////////////

    // First stage lines up with the taps, second with the PE sums
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl_tap  <= '0;
            psum_ctrl <= '0;
        end else begin
            ctrl_tap.p_valid <= ifm_read && (col >= COL_W'(`KSIZE - 1));
            ctrl_tap.p_first <= (ch == '0);
            ctrl_tap.p_col   <= win_col[IDX_W-1:0];
            ctrl_tap.p_last  <= (ch == ci_q) && last_col;
            psum_ctrl        <= ctrl_tap;
        end
    end

endmodule

// File: rtl/ofm_writeback.sv
////////////////////////////////////////////////////////////
// Output write-back and end-of-run pulse
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "conv_settings.svh"

module ofm_writeback (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            ready,
    input  conv_data_pkg::ofm_col_t         ofm_in,
    output logic [$clog2(`OUT_COLS)-1:0]    rd_col,
    output conv_data_pkg::ofm_col_t         ofm,
    output logic                            ofm_valid,
    output logic                            done
);

    localparam int IDX_W = $clog2(`OUT_COLS);

    logic busy;
    logic last_col;

    assign last_col = (rd_col == IDX_W'(`OUT_COLS - 1));

    always_ff @(posedge clk) begin
        if (ready || busy) begin
            ofm <= ofm_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            rd_col    <= '0;
            ofm_valid <= 1'b0;
            done      <= 1'b0;
        end else begin
            ofm_valid <= ready || busy;
            // Last valid word is out and nothing follows
            done      <= ofm_valid && !busy;
            if (ready || busy) begin
                rd_col <= last_col ? '0 : rd_col + 1'b1;
                busy   <= !last_col;
            end
        end
    end

endmodule

// File: rtl/psum_buf.sv
////////////////////////////////////////////////////////////
// Partial-sum column memory, accumulates over channels
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "conv_settings.svh"

module psum_buf (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  conv_ctrl_pkg::psum_ctrl_t               psum_ctrl,
    input  conv_data_pkg::psum_t [`OUT_ROWS-1:0]    sums,
    input  logic [$clog2(`OUT_COLS)-1:0]            rd_col,
    output conv_data_pkg::ofm_col_t                 ofm,
    output logic                                    ready
);
    import conv_data_pkg::*;

    ofm_col_t mem [`OUT_COLS];

    // First channel overwrites, later channels add
    always_ff @(posedge clk) begin
        if (psum_ctrl.p_valid) begin
            for (int r = 0; r < `OUT_ROWS; r++) begin
                if (psum_ctrl.p_first) begin
                    mem[psum_ctrl.p_col].row[r] <= sums[r];
                end else begin
                    mem[psum_ctrl.p_col].row[r] <= mem[psum_ctrl.p_col].row[r] + sums[r];
                end
            end
        end
    end

    // All columns final one cycle after the last write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ready <= 1'b0;
        end else begin
            ready <= psum_ctrl.p_valid && psum_ctrl.p_last;
        end
    end

    assign ofm = mem[rd_col];

endmodule

// File: rtl/pe_array.sv
////////////////////////////////////////////////////////////
// PE array, kernel-row dot products and output-row sums
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "conv_settings.svh"

module pe_array (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  conv_data_pkg::pixel_t [`IFM_ROWS-1:0][`KSIZE-1:0] ifm_taps,
    input  conv_data_pkg::pixel_t [`KSIZE-1:0][`KSIZE-1:0]    wgt_taps,
    output conv_data_pkg::psum_t [`OUT_ROWS-1:0]              sums
);
    import conv_data_pkg::*;

    psum_t [`OUT_ROWS-1:0][`KSIZE-1:0] dot;
    psum_t [`OUT_ROWS-1:0]             row_sum;

    // Output row r, kernel row k uses IFM row r+k
    always_comb begin
        for (int r = 0; r < `OUT_ROWS; r++) begin
            for (int k = 0; k < `KSIZE; k++) begin
                dot[r][k] = '0;
                for (int j = 0; j < `KSIZE; j++) begin
                    dot[r][k] = dot[r][k]
                              + psum_t'(ifm_taps[r+k][j]) * psum_t'(wgt_taps[k][j]);
                end
            end
        end
    end

    always_comb begin
        for (int r = 0; r < `OUT_ROWS; r++) begin
            row_sum[r] = '0;
            for (int k = 0; k < `KSIZE; k++) begin
                row_sum[r] = row_sum[r] + dot[r][k];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sums <= '0;
        end else begin
            sums <= row_sum;
        end
    end

endmodule

// File: rtl/tap_shift.sv
////////////////////////////////////////////////////////////
// Three-tap column shift register over byte lanes
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "conv_settings.svh"

module tap_shift #(
    parameter int LANES = `IFM_ROWS
) (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          shift,
    input  conv_data_pkg::pixel_t [LANES-1:0]             lanes_in,
    output conv_data_pkg::pixel_t [LANES-1:0][`KSIZE-1:0] taps
);

    // Tap 0 is the oldest column, the new byte enters at the top
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            taps <= '0;
        end else if (shift) begin
            for (int l = 0; l < LANES; l++) begin
                for (int j = 0; j < `KSIZE - 1; j++) begin
                    taps[l][j] <= taps[l][j+1];
                end
                taps[l][`KSIZE-1] <= lanes_in[l];
            end
        end
    end

endmodule

// File: rtl/conv_ctrl_pkg.sv
////////////////////////////////////////////////////////////
// Sequencer control and run configuration types
////////////////////////////////////////////////////////////

`include "conv_settings.svh"

package conv_ctrl_pkg;

    // Number of input channels minus one
    typedef logic [`CH_W-1:0] cfg_ci_t;

    // Partial-sum buffer command, aligned with the PE outputs
    typedef struct packed {
        logic                          p_valid;
        logic                          p_first;
        logic [$clog2(`OUT_COLS)-1:0]  p_col;
        logic                          p_last;
    } psum_ctrl_t;

endpackage

// File: rtl/conv_data_pkg.sv
////////////////////////////////////////////////////////////
// Pixel, weight, partial-sum and column data types
////////////////////////////////////////////////////////////

`include "conv_settings.svh"

package conv_data_pkg;

    // Pixels and weights share one byte format
    typedef logic [`PIX_W-1:0]  pixel_t;
    typedef logic [`PSUM_W-1:0] psum_t;

    // One IFM column, lane r is input row r
    typedef struct packed {
        pixel_t [`IFM_ROWS-1:0] px;
    } ifm_col_t;

    // One kernel column, lane k is kernel row k
    typedef struct packed {
        pixel_t [`KSIZE-1:0] w;
    } wgt_col_t;

    typedef struct packed {
        psum_t [`OUT_ROWS-1:0] row;
    } ofm_col_t;

endpackage

// File: rtl/conv_settings.svh
////////////////////////////////////////////////////////////
// Array, tile and data sizes of the convolution engine
////////////////////////////////////////////////////////////

`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

// Array shape
`define IFM_ROWS 6
`define OUT_ROWS 4
`define KSIZE    3

// Tile shape per channel
`define IFM_COLS 6
`define OUT_COLS (`IFM_COLS - `KSIZE + 1)

// Data widths
`define PIX_W    8
`define PSUM_W   32
`define CH_W     2

`endif
